/* cam_byte_packer.sv */
// Camera byte packer with write pointer and current camera bank
`include "cam_qspi_settings.svh"

module cam_byte_packer (
	input  logic                   WBs_CLK_i,   // System clock
	input  logic                   WBs_RST_i,   // Async reset, active high
	input  logic                   pix_stb_i,   // One strobe per pixel byte
	input  logic                   vsync_i,
	input  logic                   href_i,
	input  logic [`CQ_BYTE_W-1:0]  cam_dat_i,
	output cam_qspi_pkg::cq_word_t word_o,      // Packed word, first byte on top
	output logic                   word_wr_o,   // One-cycle write strobe
	output cam_qspi_pkg::cq_ptr_t  wr_ptr_o,    // Buffer slot for word_o
	output logic                   cam_bank_o   // Bank being filled
);

	logic                                byte_vld;    // Byte qualifies for packing
	logic                                last_byte;   // Fourth byte of a word
	logic [1:0]                          slot;        // Byte position in word
	logic [`CQ_WORD_W-`CQ_BYTE_W-1:0]    part;        // First three bytes
	cam_qspi_pkg::cq_ptr_t               nxt_ptr;     // Slot for the next word

	assign byte_vld   = pix_stb_i & href_i & vsync_i;
	assign last_byte  = byte_vld & (slot == 2'd3);
	assign cam_bank_o = nxt_ptr[`CQ_PTR_W-1];         // Bank of upcoming writes

	// ---------------------------------------------------------------------------
	// Slot counter and pointer
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			slot      <= '0;
			word_wr_o <= 1'b0;
			wr_ptr_o  <= '0;
			nxt_ptr   <= '0;
		end else begin
			word_wr_o <= last_byte;                   // Strobe follows 4th byte
			if (byte_vld)
				slot <= slot + 2'd1;                  // Slot kept across gaps
			if (last_byte) begin
				wr_ptr_o <= nxt_ptr;
				nxt_ptr  <= nxt_ptr + cam_qspi_pkg::cq_ptr_t'(1);  // Wraps over both banks
			end
		end
	end

	// Byte shift and word capture
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_vld)
			part <= {part[`CQ_WORD_W-2*`CQ_BYTE_W-1:0], cam_dat_i};
		if (last_byte)
			word_o <= {part, cam_dat_i};              // MSB first
	end

endmodule

/* cam_qspi_checker.sv */
// Bound assertions for host acknowledge and quad SPI chip select behavior
`include "cam_qspi_settings.svh"

module cam_qspi_checker (
	input logic       WBs_CLK_i,    // System clock
	input logic       WBs_RST_i,    // Async reset, active high
	input logic       wbs_ack_o,
	input logic       mode_write,   // Decoded host write mode
	input logic       quad_ncs_o,
	input logic [3:0] quad_out_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// ---------------------------------------------------------------------------
	// Host port
	a_ack_single: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |=> !wbs_ack_o) else $error("acknowledge held for two cycles");

	// SRAM interface
	a_ncs_mode: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		!mode_write |-> quad_ncs_o) else $error("chip select low outside write mode");

	a_ncs_gap: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$rose(quad_ncs_o) |=> quad_ncs_o) else $error("burst gap shorter than two cycles");

	a_lanes_idle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		quad_ncs_o |-> (quad_out_o == 4'h0)) else $error("lanes driven while deselected");

endmodule

bind cam_qspi_top cam_qspi_checker i_checker (
	.WBs_CLK_i  (WBs_CLK_i),
	.WBs_RST_i  (WBs_RST_i),
	.wbs_ack_o  (wbs_ack_o),
	.mode_write (mode_write),
	.quad_ncs_o (quad_ncs_o),
	.quad_out_o (quad_out_o)
);

/* cam_qspi_pkg.sv */
// Shared word, pointer, address, status and state types
`include "cam_qspi_settings.svh"

package cam_qspi_pkg;

	typedef logic [`CQ_WORD_W-1:0]  cq_word_t;     // One packed buffer word
	typedef logic [`CQ_PTR_W-1:0]   cq_ptr_t;      // Bank bit plus word index
	typedef logic [`CQ_QADDR_W-1:0] cq_qaddr_t;    // SRAM byte address
	typedef logic [`CQ_WORD_W-1:0]  cq_status_t;   // Host status readback

	// Write sequencer phases
	typedef enum logic [2:0] {
		SEQ_IDLE,       // Wait for first full bank
		SEQ_CMD,        // Command bits on lane 0
		SEQ_ADDR,       // Six address nibbles
		SEQ_DATA,       // Word nibbles
		SEQ_CLOSE,      // Chip select released
		SEQ_GAP,        // Idle spacing between bursts
		SEQ_HANDOVER    // Bank done, wait for camera to move on
	} cq_seq_state_t;

	// Shifter operation
	typedef enum logic [2:0] {
		SH_HOLD,
		SH_LOAD_CMD,
		SH_LOAD_ADDR,
		SH_LOAD_DATA,
		SH_SHIFT
	} cq_shift_op_t;

endpackage

/* cam_qspi_settings.svh */
// Widths, depths, burst length, SPI command code and status bit positions
`ifndef CAM_QSPI_SETTINGS_SVH
`define CAM_QSPI_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Datapath sizes
`define CQ_WORD_W        32        // Buffer word
`define CQ_BYTE_W        8         // Camera byte
`define CQ_BANK_DEPTH    512       // Words per bank
`define CQ_PTR_W         10        // Buffer pointer, MSB selects bank

// ---------------------------------------------------------------------------
// Quad SPI SRAM transfer
`define CQ_BURST_WORDS   128       // Words per chip-select burst
`define CQ_QADDR_W       24        // SRAM byte address
`define CQ_BURST_BYTES   24'd512   // Address step per burst
`define CQ_CMD_WRITE     8'h38     // Quad write command

// Host status word and mode register
`define CQ_ST_BANK_BIT   0
`define CQ_ST_FIN_BIT    3
`define CQ_ST_VSYNC_BIT  8
`define CQ_MODE_WRITE    2'b10

`endif

/* cam_qspi_stimulus.txt */
# name action(0 none,1 set mode,2 abort+restart) words gaps mode bursts addr0(hex)
# rd_start(hex) status_before(hex)
host_status 1 0 0 0 0 000000 000 108
idle_push 0 600 0 0 0 000000 000 108
write_bank0 1 0 0 2 4 000000 000 109
gap_wrap 0 424 1 2 4 000800 200 109
abort_restart 2 512 0 2 4 000000 000 108

/* cam_qspi_top.sv */
// Camera to quad SPI SRAM streamer top level
`include "cam_qspi_settings.svh"

module cam_qspi_top (
	input  logic                     WBs_CLK_i,   // System clock
	input  logic                     WBs_RST_i,   // Async reset, active high
	// Camera
	input  logic                     pix_stb_i,
	input  logic                     vsync_i,
	input  logic                     href_i,
	input  logic [`CQ_BYTE_W-1:0]    cam_dat_i,
	// Host register port
	input  logic                     wbs_cyc_i,
	input  logic                     wbs_stb_i,
	input  logic                     wbs_we_i,
	input  logic [`CQ_WORD_W-1:0]    wbs_dat_i,
	output logic                     wbs_ack_o,
	output cam_qspi_pkg::cq_status_t wbs_dat_o,
	// Quad SPI SRAM
	output logic [3:0]               quad_out_o,
	output logic                     quad_ncs_o
);

	cam_qspi_pkg::cq_word_t     word;        // Packer to buffer
	logic                       word_wr;
	cam_qspi_pkg::cq_ptr_t      wr_ptr;
	logic                       cam_bank;
	logic                       rd_en;       // Sequencer to buffer
	cam_qspi_pkg::cq_ptr_t      rd_ptr;
	cam_qspi_pkg::cq_word_t     rd_word;
	cam_qspi_pkg::cq_shift_op_t shift_op;    // Sequencer to shifter
	cam_qspi_pkg::cq_qaddr_t    qaddr;
	logic                       tx_fin;
	logic                       mode_write;

	cam_byte_packer i_packer (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.pix_stb_i  (pix_stb_i),
		.vsync_i    (vsync_i),
		.href_i     (href_i),
		.cam_dat_i  (cam_dat_i),
		.word_o     (word),
		.word_wr_o  (word_wr),
		.wr_ptr_o   (wr_ptr),
		.cam_bank_o (cam_bank)
	);

	frame_buffer_ram i_fbuf (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (word_wr),
		.wr_ptr_i  (wr_ptr),
		.wr_word_i (word),
		.rd_en_i   (rd_en),
		.rd_ptr_i  (rd_ptr),
		.rd_word_o (rd_word)
	);

	qspi_write_seq i_seq (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.mode_write_i (mode_write),
		.cam_bank_i   (cam_bank),
		.rd_en_o      (rd_en),
		.rd_ptr_o     (rd_ptr),
		.shift_op_o   (shift_op),
		.qaddr_o      (qaddr),
		.quad_ncs_o   (quad_ncs_o),
		.tx_fin_o     (tx_fin)
	);

	qspi_shift_reg i_shift (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.shift_op_i (shift_op),
		.qaddr_i    (qaddr),
		.data_i     (rd_word),
		.quad_out_o (quad_out_o)
	);

	host_status_regs i_host (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.wbs_cyc_i    (wbs_cyc_i),
		.wbs_stb_i    (wbs_stb_i),
		.wbs_we_i     (wbs_we_i),
		.wbs_dat_i    (wbs_dat_i),
		.vsync_i      (vsync_i),
		.cam_bank_i   (cam_bank),
		.tx_fin_i     (tx_fin),
		.wbs_ack_o    (wbs_ack_o),
		.wbs_dat_o    (wbs_dat_o),
		.mode_write_o (mode_write)
	);

endmodule

/* frame_buffer_ram.sv */
// Two-bank frame buffer memory with registered read port
`include "cam_qspi_settings.svh"

module frame_buffer_ram (
	input  logic                   WBs_CLK_i,   // System clock
	input  logic                   wr_en_i,     // Packer word strobe
	input  cam_qspi_pkg::cq_ptr_t  wr_ptr_i,
	input  cam_qspi_pkg::cq_word_t wr_word_i,
	input  logic                   rd_en_i,     // Sequencer fetch
	input  cam_qspi_pkg::cq_ptr_t  rd_ptr_i,
	output cam_qspi_pkg::cq_word_t rd_word_o    // Valid one cycle after rd_en_i
);

	localparam int DEPTH = 2 * `CQ_BANK_DEPTH;      // Ping and pong banks

	cam_qspi_pkg::cq_word_t mem [DEPTH];

	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i)
			mem[wr_ptr_i] <= wr_word_i;
		if (rd_en_i)
			rd_word_o <= mem[rd_ptr_i];               // Old data on same-address write
	end

endmodule

/* host_status_regs.sv */
// Host acknowledge, mode register and status word
`include "cam_qspi_settings.svh"

module host_status_regs (
	input  logic                     WBs_CLK_i,    // System clock
	input  logic                     WBs_RST_i,    // Async reset, active high
	input  logic                     wbs_cyc_i,
	input  logic                     wbs_stb_i,
	input  logic                     wbs_we_i,
	input  logic [`CQ_WORD_W-1:0]    wbs_dat_i,    // Mode register write data
	input  logic                     vsync_i,
	input  logic                     cam_bank_i,
	input  logic                     tx_fin_i,
	output logic                     wbs_ack_o,
	output cam_qspi_pkg::cq_status_t wbs_dat_o,    // Status readback
	output logic                     mode_write_o  // Write mode selected
);

	logic       acc;        // Qualifying bus cycle
	logic [1:0] mode_reg;   // Host mode bits

	assign acc          = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
	assign mode_write_o = (mode_reg == `CQ_MODE_WRITE);

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o <= 1'b0;
			mode_reg  <= '0;
		end else begin
			wbs_ack_o <= acc;                      // Single-cycle ack
			if (acc && wbs_we_i)
				mode_reg <= wbs_dat_i[1:0];
		end
	end

	// Status word, unused bits zero
	always_comb begin
		wbs_dat_o                   = '0;
		wbs_dat_o[`CQ_ST_BANK_BIT]  = cam_bank_i;
		wbs_dat_o[`CQ_ST_FIN_BIT]   = tx_fin_i;
		wbs_dat_o[`CQ_ST_VSYNC_BIT] = vsync_i;
	end

endmodule

/* qspi_shift_reg.sv */
// Quad SPI output shifter for command, address and data
`include "cam_qspi_settings.svh"

module qspi_shift_reg (
	input  logic                       WBs_CLK_i,   // System clock
	input  logic                       WBs_RST_i,   // Async reset, active high
	input  cam_qspi_pkg::cq_shift_op_t shift_op_i,
	input  cam_qspi_pkg::cq_qaddr_t    qaddr_i,     // Burst start address
	input  cam_qspi_pkg::cq_word_t     data_i,      // Word from frame buffer
	output logic [3:0]                 quad_out_o   // SPI lanes 3..0
);

	localparam int         W   = `CQ_WORD_W;
	localparam int         QW  = `CQ_QADDR_W;
	localparam logic [7:0] CMD = `CQ_CMD_WRITE;

	cam_qspi_pkg::cq_word_t sreg;       // Remaining bits, left aligned
	logic                   cmd_mode;   // Single-bit shifting on lane 0

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i)
			cmd_mode <= 1'b0;
		else if (shift_op_i == cam_qspi_pkg::SH_LOAD_CMD)
			cmd_mode <= 1'b1;
		else if (shift_op_i == cam_qspi_pkg::SH_LOAD_ADDR ||
		         shift_op_i == cam_qspi_pkg::SH_LOAD_DATA)
			cmd_mode <= 1'b0;
	end

	// Loads store the value minus the symbol already on the lanes
	always_ff @(posedge WBs_CLK_i) begin
		case (shift_op_i)
			cam_qspi_pkg::SH_LOAD_CMD:  sreg <= {CMD[6:0], {(W-7){1'b0}}};
			cam_qspi_pkg::SH_LOAD_ADDR: sreg <= {qaddr_i[QW-5:0], {(W-QW+4){1'b0}}};
			cam_qspi_pkg::SH_LOAD_DATA: sreg <= {data_i[W-5:0], 4'h0};
			cam_qspi_pkg::SH_SHIFT:     sreg <= cmd_mode ? (sreg << 1) : (sreg << 4);
			default: ;                                  // Hold
		endcase
	end

	// ---------------------------------------------------------------------------
	// Lane drive, leading symbol straight from the load source
	always_comb begin
		case (shift_op_i)
			cam_qspi_pkg::SH_LOAD_CMD:  quad_out_o = {3'b000, CMD[7]};
			cam_qspi_pkg::SH_LOAD_ADDR: quad_out_o = qaddr_i[QW-1:QW-4];
			cam_qspi_pkg::SH_LOAD_DATA: quad_out_o = data_i[W-1:W-4];
			cam_qspi_pkg::SH_SHIFT:     quad_out_o = cmd_mode ? {3'b000, sreg[W-1]} : sreg[W-1:W-4];
			default:                    quad_out_o = 4'h0;   // Lanes idle
		endcase
	end

endmodule

/* qspi_write_seq.sv */
// Quad SPI write burst sequencer with bank handover
`include "cam_qspi_settings.svh"

module qspi_write_seq (
	input  logic                       WBs_CLK_i,     // System clock
	input  logic                       WBs_RST_i,     // Async reset, active high
	input  logic                       mode_write_i,  // Host write mode
	input  logic                       cam_bank_i,    // Bank the camera is filling
	output logic                       rd_en_o,       // Buffer fetch
	output cam_qspi_pkg::cq_ptr_t      rd_ptr_o,
	output cam_qspi_pkg::cq_shift_op_t shift_op_o,
	output cam_qspi_pkg::cq_qaddr_t    qaddr_o,       // Current burst address
	output logic                       quad_ncs_o,    // SRAM chip select, low active
	output logic                       tx_fin_o       // Read pointer at bank start
);

	localparam logic [2:0] CMD_LAST  = 3'd7;          // 8 command bits
	localparam logic [2:0] ADDR_LAST = 3'd5;          // 6 address nibbles
	localparam logic [2:0] NIB_LAST  = 3'd7;          // 8 nibbles per word
	localparam logic [2:0] GAP_LAST  = 3'd1;          // 2 gap cycles
	localparam int         WC_W      = $clog2(`CQ_BURST_WORDS);
	localparam logic [WC_W-1:0] WORD_LAST = WC_W'(`CQ_BURST_WORDS - 1);

	cam_qspi_pkg::cq_seq_state_t state;
	logic [2:0]                  phase;      // Bit or nibble index in phase
	logic [WC_W-1:0]             word_cnt;   // Word index in burst
	logic                        tx_bank;    // Bank being sent
	logic                        bank_rdy;   // Camera has left tx_bank
	logic                        active;     // Chip select phases

	assign tx_bank  = rd_ptr_o[`CQ_PTR_W-1];
	assign bank_rdy = (cam_bank_i != tx_bank);
	assign tx_fin_o = (rd_ptr_o[`CQ_PTR_W-2:0] == '0);
	assign active   = mode_write_i & (state == cam_qspi_pkg::SEQ_CMD ||
	                                  state == cam_qspi_pkg::SEQ_ADDR ||
	                                  state == cam_qspi_pkg::SEQ_DATA);

	assign quad_ncs_o = ~active;                      // Released at once on mode clear

	// Fetch one cycle ahead of each word's first nibble
	assign rd_en_o = mode_write_i &
	                 ((state == cam_qspi_pkg::SEQ_ADDR && phase == ADDR_LAST) ||
	                  (state == cam_qspi_pkg::SEQ_DATA && phase == NIB_LAST &&
	                   word_cnt != WORD_LAST));

	// ---------------------------------------------------------------------------
	// Shifter control
	always_comb begin
		shift_op_o = cam_qspi_pkg::SH_HOLD;
		if (mode_write_i) begin
			case (state)
				cam_qspi_pkg::SEQ_CMD:
					shift_op_o = (phase == '0) ? cam_qspi_pkg::SH_LOAD_CMD : cam_qspi_pkg::SH_SHIFT;
				cam_qspi_pkg::SEQ_ADDR:
					shift_op_o = (phase == '0) ? cam_qspi_pkg::SH_LOAD_ADDR : cam_qspi_pkg::SH_SHIFT;
				cam_qspi_pkg::SEQ_DATA:
					shift_op_o = (phase == '0) ? cam_qspi_pkg::SH_LOAD_DATA : cam_qspi_pkg::SH_SHIFT;
				default: ;
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// Burst FSM
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state    <= cam_qspi_pkg::SEQ_IDLE;
			phase    <= '0;
			word_cnt <= '0;
			qaddr_o  <= '0;
			rd_ptr_o <= '0;
		end else if (!mode_write_i) begin
			state    <= cam_qspi_pkg::SEQ_IDLE;   // Restart from bank 0, address 0
			phase    <= '0;
			word_cnt <= '0;
			qaddr_o  <= '0;
			rd_ptr_o <= '0;
		end else begin
			if (rd_en_o)
				rd_ptr_o <= rd_ptr_o + cam_qspi_pkg::cq_ptr_t'(1);
			case (state)
				cam_qspi_pkg::SEQ_IDLE, cam_qspi_pkg::SEQ_HANDOVER: begin
					phase <= '0;
					if (bank_rdy)
						state <= cam_qspi_pkg::SEQ_CMD;   // Other bank is full
				end
				cam_qspi_pkg::SEQ_CMD: begin
					phase <= (phase == CMD_LAST) ? 3'd0 : phase + 3'd1;
					if (phase == CMD_LAST)
						state <= cam_qspi_pkg::SEQ_ADDR;
				end
				cam_qspi_pkg::SEQ_ADDR: begin
					phase    <= (phase == ADDR_LAST) ? 3'd0 : phase + 3'd1;
					word_cnt <= '0;
					if (phase == ADDR_LAST)
						state <= cam_qspi_pkg::SEQ_DATA;
				end
				cam_qspi_pkg::SEQ_DATA: begin
					phase <= phase + 3'd1;            // Wraps after each word
					if (phase == NIB_LAST) begin
						word_cnt <= word_cnt + WC_W'(1);
						if (word_cnt == WORD_LAST)
							state <= cam_qspi_pkg::SEQ_CLOSE;
					end
				end
				cam_qspi_pkg::SEQ_CLOSE: begin
					qaddr_o <= qaddr_o + `CQ_BURST_BYTES;   // Wraps at 24 bits
					phase   <= '0;
					state   <= cam_qspi_pkg::SEQ_GAP;
				end
				cam_qspi_pkg::SEQ_GAP: begin
					phase <= phase + 3'd1;
					if (phase == GAP_LAST) begin
						phase <= '0;
						state <= tx_fin_o ? cam_qspi_pkg::SEQ_HANDOVER : cam_qspi_pkg::SEQ_CMD;
					end
				end
				default: state <= cam_qspi_pkg::SEQ_IDLE;
			endcase
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the camera to quad SPI testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cam_qspi -f sim.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation finished without failures"

/* sim.f */
+incdir+.
cam_qspi_pkg.sv
cam_byte_packer.sv
frame_buffer_ram.sv
qspi_shift_reg.sv
qspi_write_seq.sv
host_status_regs.sv
cam_qspi_top.sv
cam_qspi_checker.sv
tb_cam_qspi.sv

/* tb_cam_qspi.sv */
// Testbench with clock, reset, file driven stimulus, burst capture and compare tasks
`include "cam_qspi_settings.svh"

module tb_cam_qspi;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BURST_NIBS = 8 + 6 + `CQ_BURST_WORDS * 8;   // Cycles with ncs low

	logic                     WBs_CLK_i = 1'b0;
	logic                     WBs_RST_i;
	logic                     pix_stb_i, vsync_i, href_i;
	logic [`CQ_BYTE_W-1:0]    cam_dat_i;
	logic                     wbs_cyc_i, wbs_stb_i, wbs_we_i;
	logic [`CQ_WORD_W-1:0]    wbs_dat_i;
	logic                     wbs_ack_o;
	cam_qspi_pkg::cq_status_t wbs_dat_o;
	logic [3:0]               quad_out_o;
	logic                     quad_ncs_o;

	cam_qspi_pkg::cq_word_t   exp_mem [2*`CQ_BANK_DEPTH];   // Model of buffer contents
	cam_qspi_pkg::cq_ptr_t    cam_ptr;                      // Model write pointer
	cam_qspi_pkg::cq_word_t   exp_q[$];                     // Expected burst words
	logic [3:0]               nib_q[$];                     // Nibbles of current burst
	cam_qspi_pkg::cq_word_t   got_words[$];
	cam_qspi_pkg::cq_qaddr_t  got_addr[$];
	logic [7:0]               got_cmd[$];
	int                       abort_cnt, lane_err, mism_cnt, fail_cnt;
	int                       chk_burst;
	logic                     timed_out;

	always #5 WBs_CLK_i = ~WBs_CLK_i;                      // 10 ns period

	cam_qspi_top i_dut (.*);

	// ---------------------------------------------------------------------------
	// Burst capture, one nibble per cycle while selected
	task automatic decode_burst();
		logic [7:0]              cmd;
		cam_qspi_pkg::cq_qaddr_t addr;
		cam_qspi_pkg::cq_word_t  wd;
		cmd  = '0;
		addr = '0;
		for (int i = 0; i < 8; i++) begin
			cmd = {cmd[6:0], nib_q[i][0]};
			if (nib_q[i][3:1] != 3'b000)
				lane_err++;                                  // Upper lanes must idle
		end
		for (int i = 8; i < 14; i++)
			addr = {addr[`CQ_QADDR_W-5:0], nib_q[i]};
		for (int w = 0; w < `CQ_BURST_WORDS; w++) begin
			wd = '0;
			for (int n = 0; n < 8; n++)
				wd = {wd[`CQ_WORD_W-5:0], nib_q[14+w*8+n]};
			got_words.push_back(wd);
		end
		got_cmd.push_back(cmd);
		got_addr.push_back(addr);
	endtask

	always @(negedge WBs_CLK_i) begin                        // Mid-cycle sample
		if (quad_ncs_o === 1'b0)
			nib_q.push_back(quad_out_o);
		else if (nib_q.size() != 0) begin
			if (nib_q.size() == BURST_NIBS)
				decode_burst();
			else
				abort_cnt++;                                 // Cut short by mode clear
			nib_q.delete();
		end
	end

	// ---------------------------------------------------------------------------
	// Compare tasks
	task automatic check_status(string tn, cam_qspi_pkg::cq_status_t e, cam_qspi_pkg::cq_status_t a);
		if (a !== e) begin
			$display("mismatch %s status: expected %h actual %h", tn, e, a);
			mism_cnt++;
		end
	endtask

	task automatic check_addr(string tn, cam_qspi_pkg::cq_qaddr_t e, cam_qspi_pkg::cq_qaddr_t a);
		if (a !== e) begin
			$display("mismatch %s address: expected %h actual %h", tn, e, a);
			mism_cnt++;
		end
	endtask

	task automatic check_word(string tn, cam_qspi_pkg::cq_word_t e, cam_qspi_pkg::cq_word_t a);
		if (a !== e) begin
			$display("mismatch %s data: expected %h actual %h", tn, e, a);
			mism_cnt++;
		end
	endtask

	task automatic check_cmd(string tn, logic [7:0] e, logic [7:0] a);
		if (a !== e) begin
			$display("mismatch %s command: expected %h actual %h", tn, e, a);
			mism_cnt++;
		end
	endtask

	task automatic report_failure(string what);
		$display("%s", what);
		fail_cnt++;
	endtask

	// ---------------------------------------------------------------------------
	// Host single access, ack due one cycle after the strobe
	task automatic host_access(input logic we, input logic [31:0] wd,
	                           output cam_qspi_pkg::cq_status_t rd);
		int n;
		n = 0;
		@(negedge WBs_CLK_i);
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i  = we;
		wbs_dat_i = wd;
		do begin
			@(negedge WBs_CLK_i);
			n++;
		end while (wbs_ack_o !== 1'b1 && n < 8);
		rd = wbs_dat_o;
		if (wbs_ack_o !== 1'b1) begin
			report_failure("host acknowledge never arrived");
			timed_out = 1'b1;
		end else if (n != 1)
			report_failure("host acknowledge was not one cycle after the strobe");
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
	endtask

	// Camera bytes for one word, optionally with invalid cycles
	task automatic push_word(input bit gaps);
		logic [7:0]             b;
		cam_qspi_pkg::cq_word_t w;
		int                     k;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			for (int g = gaps ? int'($urandom % 3) : 0; g > 0; g--) begin
				k = int'($urandom % 3);
				@(negedge WBs_CLK_i);
				pix_stb_i = (k != 0);
				href_i    = (k != 1);
				vsync_i   = (k != 2);
				cam_dat_i = 8'($urandom);
			end
			b = 8'($urandom);
			@(negedge WBs_CLK_i);
			{pix_stb_i, href_i, vsync_i} = 3'b111;
			cam_dat_i = b;
			w = {w[23:0], b};                                // First byte ends on top
		end
		@(negedge WBs_CLK_i);
		{pix_stb_i, href_i, vsync_i} = 3'b001;
		exp_mem[cam_ptr] = w;
		cam_ptr++;
	endtask

	task automatic wait_bursts(input int target);
		int n;
		n = 0;
		while (!timed_out && got_cmd.size() < target && n < target * 3000 + 3000) begin
			@(negedge WBs_CLK_i);
			n++;
		end
		if (!timed_out && got_cmd.size() < target) begin
			report_failure("timeout waiting for quad SPI bursts");
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_ncs_low();
		int n;
		n = 0;
		while (quad_ncs_o !== 1'b0 && n < 200) begin
			@(negedge WBs_CLK_i);
			n++;
		end
		if (quad_ncs_o !== 1'b0) begin
			report_failure("timeout waiting for chip select to go low");
			timed_out = 1'b1;
		end
	endtask

	// ---------------------------------------------------------------------------
	// Test sequence from the stimulus file
	initial begin
		int                        fd, act, nwords, gaps, mode, nb, ab0;
		logic [23:0]               addr0;
		logic [9:0]                rd0;
		cam_qspi_pkg::cq_status_t  exp_st, st;
		string                     line, tn;
		void'($urandom(95614));
		{pix_stb_i, href_i, vsync_i, cam_dat_i} = '0;
		{wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_dat_i} = '0;
		{abort_cnt, lane_err, mism_cnt, fail_cnt, chk_burst} = '0;
		cam_ptr   = '0;
		timed_out = 1'b0;
		WBs_RST_i = 1'b1;
		repeat (3) @(posedge WBs_CLK_i);
		@(negedge WBs_CLK_i);
		WBs_RST_i = 1'b0;
		vsync_i   = 1'b1;
		fd = $fopen("cam_qspi_stimulus.txt", "r");
		if (fd == 0) begin
			report_failure("stimulus file could not be opened");
			timed_out = 1'b1;
		end
		while (!timed_out && !$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() < 4 || line[0] == 8'h23)
				continue;
			void'($sscanf(line, "%s %d %d %d %d %d %h %h %h",
			              tn, act, nwords, gaps, mode, nb, addr0, rd0, exp_st));
			host_access(1'b0, '0, st);
			check_status(tn, exp_st, st);
			vsync_i = 1'b0;                                  // Bit 8 must follow vsync
			host_access(1'b0, '0, st);
			check_status(tn, exp_st & ~(cam_qspi_pkg::cq_status_t'(1) << `CQ_ST_VSYNC_BIT), st);
			vsync_i = 1'b1;
			if (act == 1)
				host_access(1'b1, 32'(mode), st);
			for (int i = 0; i < nwords; i++)
				push_word(gaps != 0);
			if (act == 2) begin
				ab0 = abort_cnt;
				wait_ncs_low();
				repeat (200) @(negedge WBs_CLK_i);
				host_access(1'b1, 32'h0, st);
				if (quad_ncs_o !== 1'b1)
					report_failure("chip select stayed low after mode clear");
				@(negedge WBs_CLK_i);
				if (abort_cnt != ab0 + 1)
					report_failure("interrupted burst was not seen");
				host_access(1'b1, 32'(mode), st);
			end
			wait_bursts(chk_burst + nb);
			for (int b = 0; b < nb && !timed_out; b++) begin
				check_cmd(tn, `CQ_CMD_WRITE, got_cmd[chk_burst+b]);
				check_addr(tn, addr0 + 24'(b) * `CQ_BURST_BYTES, got_addr[chk_burst+b]);
				for (int w = 0; w < `CQ_BURST_WORDS; w++)
					exp_q.push_back(exp_mem[rd0 + 10'(b * `CQ_BURST_WORDS + w)]);
				for (int w = 0; w < `CQ_BURST_WORDS; w++)
					check_word(tn, exp_q.pop_front(),
					           got_words[(chk_burst+b)*`CQ_BURST_WORDS+w]);
			end
			chk_burst += nb;
			repeat (30) @(negedge WBs_CLK_i);
			if (!timed_out && got_cmd.size() != chk_burst)
				report_failure($sformatf("%s: unexpected number of bursts", tn));
		end
		if (fd != 0)
			$fclose(fd);
		if (lane_err != 0)
			report_failure("upper lanes active during command phase");
		$display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
		if (mism_cnt == 0 && fail_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
